// File: filelist.f
rtl/rv_isa_pkg.sv
rtl/dmem_pkg.sv
rtl/lsu_decode.sv
rtl/store_align.sv
rtl/load_extract.sv
rtl/data_ram.sv
rtl/mem_stage.sv
test/tb_clock.sv
test/mem_stage_tb.sv

// File: rtl/data_ram.sv
module data_ram (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req,
    input  dmem_pkg::dmem_idx_t  rd_idx,
    input  logic                 wen,
    input  dmem_pkg::dmem_idx_t  wr_idx,
    input  rv_isa_pkg::word_t    wr_data,
    input  dmem_pkg::byte_mask_t wr_mask,
    output rv_isa_pkg::word_t    rd_word
);

    import rv_isa_pkg::*;
    import dmem_pkg::*;

    word_t mem [DMEM_WORDS];
    logic  wr_en;

    // ************************************************************************
    // read port
    // ************************************************************************

    // asynchronous read, so a same-cycle write is not yet visible here.
    always_comb begin
        if (req) begin
            rd_word = mem[rd_idx];
        end else begin
            rd_word = '0;
        end
    end

    // ************************************************************************
    // write port
    // ************************************************************************

    // writes are held off for the whole reset window.
    assign wr_en = wen && arst_n && (wr_mask != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (wr_mask[lane]) begin
                    mem[wr_idx][8*lane +: 8] <= wr_data[8*lane +: 8];
                end
            end
        end
    end

    // an unknown mask would corrupt lanes the core never meant to write.
    a_mask_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        wen |-> !$isunknown(wr_mask)
    ) else $error("data_ram: write mask is unknown while wen is high");

    // a write to an unknown word would land anywhere in the array.
    a_widx_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_idx)
    ) else $error("data_ram: write index is unknown on an enabled write");

endmodule

// File: rtl/dmem_pkg.sv
package dmem_pkg;

    // ************************************************************************
    // data memory geometry
    // ************************************************************************

    localparam int DMEM_IDX_W = 10;
    localparam int DMEM_WORDS = 1 << DMEM_IDX_W;
    localparam int LANES      = 4;

    typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;
    typedef logic [LANES-1:0]      byte_mask_t;

    // byte offset of an access inside its word.
    typedef logic [1:0] byte_off_t;

    // ************************************************************************
    // access size
    // ************************************************************************

    // SIZE_NONE marks anything that is not a valid load or store.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_NONE = 2'd3
    } access_size_e;

endpackage

// File: rtl/load_extract.sv
module load_extract (
    input  rv_isa_pkg::word_t      rd_word,
    input  dmem_pkg::byte_off_t    offset,
    input  dmem_pkg::access_size_e size,
    input  logic                   is_load,
    input  logic                   is_unsigned,
    output rv_isa_pkg::word_t      rdata
);

    import rv_isa_pkg::*;
    import dmem_pkg::*;

    word_t shifted;
    logic  byte_sign;
    logic  half_sign;

    // bring the addressed byte down to lane 0 first.
    assign shifted = rd_word >> {offset, 3'b000};

    assign byte_sign = shifted[7] & ~is_unsigned;
    assign half_sign = shifted[15] & ~is_unsigned;

    always_comb begin
        if (is_load) begin
            case (size)
                SIZE_BYTE: begin
                    rdata = {{24{byte_sign}}, shifted[7:0]};
                end
                SIZE_HALF: begin
                    rdata = {{16{half_sign}}, shifted[15:0]};
                end
                SIZE_WORD: begin
                    rdata = shifted;
                end
                default: begin
                    rdata = shifted;
                end
            endcase
        end else begin
            // non-loads see the raw shifted word.
            rdata = shifted;
        end
    end

endmodule

// File: rtl/lsu_decode.sv
module lsu_decode (
    input  rv_isa_pkg::inst_t      inst,
    output logic                   is_load,
    output logic                   is_store,
    output dmem_pkg::access_size_e size,
    output logic                   is_unsigned
);

    import rv_isa_pkg::*;
    import dmem_pkg::*;

    opcode_t opcode;
    funct3_t funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        is_load     = 1'b0;
        is_store    = 1'b0;
        size        = SIZE_NONE;
        is_unsigned = 1'b0;

        case (opcode)
            OPC_LOAD: begin
                is_load = 1'b1;
                case (funct3)
                    F3_B: begin
                        size = SIZE_BYTE;
                    end
                    F3_H: begin
                        size = SIZE_HALF;
                    end
                    F3_W: begin
                        size = SIZE_WORD;
                    end
                    F3_BU: begin
                        size        = SIZE_BYTE;
                        is_unsigned = 1'b1;
                    end
                    F3_HU: begin
                        size        = SIZE_HALF;
                        is_unsigned = 1'b1;
                    end
                    default: begin
                        size = SIZE_NONE;
                    end
                endcase
            end
            OPC_STORE: begin
                is_store = 1'b1;
                // unsigned widths do not exist for stores.
                case (funct3)
                    F3_B:    size = SIZE_BYTE;
                    F3_H:    size = SIZE_HALF;
                    F3_W:    size = SIZE_WORD;
                    default: size = SIZE_NONE;
                endcase
            end
            default: begin
                size = SIZE_NONE;
            end
        endcase
    end

endmodule

// File: rtl/mem_stage.sv
module mem_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_isa_pkg::inst_t inst,
    input  rv_isa_pkg::word_t raddr,
    input  rv_isa_pkg::word_t waddr,
    input  rv_isa_pkg::word_t wdata,
    input  logic              wen,
    input  logic              req,
    output rv_isa_pkg::word_t rdata
);

    import rv_isa_pkg::*;
    import dmem_pkg::*;

    logic         is_load;
    logic         is_store;
    logic         is_unsigned;
    access_size_e size;
    word_t        lane_data;
    byte_mask_t   lane_mask;
    word_t        rd_word;
    dmem_idx_t    rd_idx;
    dmem_idx_t    wr_idx;
    byte_off_t    rd_off;

    // word indices drop the byte offset and wrap at the RAM depth.
    assign rd_idx = raddr[DMEM_IDX_W+1:2];
    assign wr_idx = waddr[DMEM_IDX_W+1:2];
    assign rd_off = raddr[1:0];

    lsu_decode u_decode (
        .inst        (inst),
        .is_load     (is_load),
        .is_store    (is_store),
        .size        (size),
        .is_unsigned (is_unsigned)
    );

    store_align u_store_align (
        .size      (size),
        .is_store  (is_store),
        .waddr     (waddr),
        .wdata     (wdata),
        .lane_data (lane_data),
        .lane_mask (lane_mask)
    );

    data_ram u_ram (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .rd_idx  (rd_idx),
        .wen     (wen),
        .wr_idx  (wr_idx),
        .wr_data (lane_data),
        .wr_mask (lane_mask),
        .rd_word (rd_word)
    );

    load_extract u_load_extract (
        .rd_word     (rd_word),
        .offset      (rd_off),
        .size        (size),
        .is_load     (is_load),
        .is_unsigned (is_unsigned),
        .rdata       (rdata)
    );

endmodule

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // ************************************************************************
    // base integer widths
    // ************************************************************************

    localparam int XLEN   = 32;
    localparam int OPC_W  = 7;
    localparam int F3_W_B = 3;

    // a data word and an address share the same width on RV32I.
    typedef logic [XLEN-1:0]   word_t;
    typedef logic [XLEN-1:0]   inst_t;
    typedef logic [OPC_W-1:0]  opcode_t;
    typedef logic [F3_W_B-1:0] funct3_t;

    // ************************************************************************
    // opcodes used by the memory stage
    // ************************************************************************

    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // ************************************************************************
    // funct3 width codes
    // ************************************************************************

    // stores only use the first three; the unsigned codes are load-only.
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

endpackage

// File: rtl/store_align.sv
module store_align (
    input  dmem_pkg::access_size_e size,
    input  logic                   is_store,
    input  rv_isa_pkg::word_t      waddr,
    input  rv_isa_pkg::word_t      wdata,
    output rv_isa_pkg::word_t      lane_data,
    output dmem_pkg::byte_mask_t   lane_mask
);

    import rv_isa_pkg::*;
    import dmem_pkg::*;

    byte_off_t  offset;
    byte_mask_t base_mask;

    // the lane offset follows the write address, not the read address.
    assign offset = waddr[1:0];

    // mask before shifting, one bit per byte the store covers.
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                base_mask = 4'b0001;
            end
            SIZE_HALF: begin
                base_mask = 4'b0011;
            end
            SIZE_WORD: begin
                base_mask = 4'b1111;
            end
            default: begin
                base_mask = 4'b0000;
            end
        endcase
    end

    // lanes shifted past byte 3 simply fall off the word.
    always_comb begin
        if (is_store) begin
            lane_mask = base_mask << offset;
        end else begin
            lane_mask = '0;
        end
    end

    assign lane_data = wdata << {offset, 3'b000};

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module mem_stage_tb \
    -f filelist.f \
    -o mem_stage_sim

./obj_dir/mem_stage_sim > sim.log 2>&1
cat sim.log

if grep -q -F "** FAIL **" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"

// File: test/mem_stage_tb.sv
module mem_stage_tb;

    import rv_isa_pkg::*;
    import dmem_pkg::*;

    localparam int SEED        = 32'h183d8c41;
    localparam int N_RANDOM    = 950;
    localparam int N_WINDOW    = 16;
    localparam int WINDOW_BASE = DMEM_WORDS - 8;
    // a random access takes at most two cycles and the directed tests about 100 more.
    localparam int TIMEOUT_CYCLES = 2 * (2 * N_RANDOM + 100);

    logic  clk;
    logic  arst_n;
    inst_t inst;
    word_t raddr;
    word_t waddr;
    word_t wdata;
    logic  wen;
    logic  req;
    word_t rdata;

    // byte-addressed model of the RAM contents.
    logic [7:0] ref_mem [DMEM_WORDS*LANES];

    int errors          = 0;
    int checks          = 0;
    int tests_run       = 0;
    int tests_failed    = 0;
    int cycle_count     = 0;
    int errors_at_start = 0;

    tb_clock clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mem_stage dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .inst   (inst),
        .raddr  (raddr),
        .waddr  (waddr),
        .wdata  (wdata),
        .wen    (wen),
        .req    (req),
        .rdata  (rdata)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // ************************************************************************
    // reference model
    // ************************************************************************

    function automatic inst_t make_inst(opcode_t opcode, funct3_t funct3);
        inst_t word;
        word        = '0;
        word[6:0]   = opcode;
        word[14:12] = funct3;
        return word;
    endfunction

    function automatic int byte_index(word_t addr, int lane);
        return int'(addr[DMEM_IDX_W+1:2]) * LANES + lane;
    endfunction

    function automatic word_t window_addr(int slot, int off);
        word_t addr;
        addr                  = $urandom;
        addr[DMEM_IDX_W+1:2]  = dmem_idx_t'((WINDOW_BASE + slot) % DMEM_WORDS);
        addr[1:0]             = byte_off_t'(off);
        return addr;
    endfunction

    function automatic void model_store(funct3_t funct3, word_t addr, word_t data);
        int nbytes;
        int off;
        nbytes = (funct3 == F3_B) ? 1 : ((funct3 == F3_H) ? 2 : 4);
        off    = int'(addr[1:0]);
        // bytes beyond lane 3 are dropped; the access is never split.
        for (int k = 0; k < nbytes; k++) begin
            if (off + k < LANES) begin
                ref_mem[byte_index(addr, off + k)] = data[8*k +: 8];
            end
        end
    endfunction

    function automatic word_t model_word(word_t addr);
        return {ref_mem[byte_index(addr, 3)], ref_mem[byte_index(addr, 2)],
                ref_mem[byte_index(addr, 1)], ref_mem[byte_index(addr, 0)]};
    endfunction

    function automatic word_t model_load(funct3_t funct3, word_t addr);
        logic [7:0] b [LANES];
        word_t      result;
        int         off;
        off = int'(addr[1:0]);
        // the word is shifted down by the offset, zeros fill from the top.
        for (int k = 0; k < LANES; k++) begin
            b[k] = (off + k < LANES) ? ref_mem[byte_index(addr, off + k)] : 8'h00;
        end
        case (funct3)
            F3_B:    result = {{24{b[0][7]}}, b[0]};
            F3_BU:   result = {24'h0, b[0]};
            F3_H:    result = {{16{b[1][7]}}, b[1], b[0]};
            F3_HU:   result = {16'h0, b[1], b[0]};
            default: result = {b[3], b[2], b[1], b[0]};
        endcase
        return result;
    endfunction

    // ************************************************************************
    // drivers and checks
    // ************************************************************************

    task automatic drive_idle();
        inst  = '0;
        raddr = '0;
        waddr = '0;
        wdata = '0;
        wen   = 1'b0;
        req   = 1'b0;
    endtask

    task automatic store_op(funct3_t funct3, word_t addr, word_t data);
        @(negedge clk);
        inst  = make_inst(OPC_STORE, funct3);
        waddr = addr;
        wdata = data;
        wen   = 1'b1;
        req   = 1'b0;
        model_store(funct3, addr, data);
    endtask

    task automatic load_op(funct3_t funct3, word_t addr, output word_t got);
        @(negedge clk);
        inst  = make_inst(OPC_LOAD, funct3);
        raddr = addr;
        wen   = 1'b0;
        req   = 1'b1;
        @(negedge clk);
        got = rdata;
    endtask

    task automatic check_word(word_t got, word_t expected, string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_mask_effect(word_t addr, word_t got);
        word_t expected;
        expected = model_word(addr);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: word at %h reads %h, expected %h",
                     $time, addr, got, expected);
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test(string name);
        int new_errors;
        new_errors = errors - errors_at_start;
        if (new_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, new_errors);
        end
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************

    task automatic reset_then_word();
        word_t addr;
        word_t data;
        word_t got;
        start_test();
        addr      = $urandom;
        addr[1:0] = 2'b00;
        data      = $urandom | 32'h1;
        // this store falls inside the reset window and must be dropped.
        @(negedge clk);
        inst  = make_inst(OPC_STORE, F3_W);
        waddr = addr;
        wdata = data;
        wen   = 1'b1;
        @(negedge clk);
        drive_idle();
        wait (arst_n === 1'b1);
        load_op(F3_W, addr, got);
        checks++;
        if (got === data) begin
            errors++;
            $display("error at %0t: a store issued during reset was written to the RAM", $time);
        end
        data = ~data;
        store_op(F3_W, addr, data);
        load_op(F3_W, addr, got);
        check_word(got, data, "word load after word store");
        finish_test("reset and word access");
    endtask

    task automatic masked_stores();
        word_t   base;
        word_t   got;
        funct3_t widths [2] = '{F3_B, F3_H};
        start_test();
        base      = $urandom;
        base[1:0] = 2'b00;
        foreach (widths[w]) begin
            for (int off = 0; off < LANES; off++) begin
                store_op(F3_W, base, $urandom);
                store_op(F3_W, base + 32'd4, $urandom);
                store_op(widths[w], base + word_t'(off), $urandom);
                load_op(F3_W, base, got);
                check_mask_effect(base, got);
                // a half at offset 3 must not spill into the next word.
                load_op(F3_W, base + 32'd4, got);
                check_mask_effect(base + 32'd4, got);
            end
        end
        finish_test("byte and half stores");
    endtask

    task automatic signed_loads();
        word_t   base;
        word_t   got;
        word_t   fill;
        funct3_t kinds [4] = '{F3_B, F3_H, F3_BU, F3_HU};
        start_test();
        base      = $urandom;
        base[1:0] = 2'b00;
        for (int off = 0; off < LANES; off++) begin
            // alternate lane sign bits so both extensions are seen.
            if (off % 2 == 0) begin
                fill = $urandom | 32'h8080_8080;
            end else begin
                fill = $urandom & 32'h7f7f_7f7f;
            end
            store_op(F3_W, base, fill);
            foreach (kinds[k]) begin
                load_op(kinds[k], base + word_t'(off), got);
                check_word(got, model_load(kinds[k], base + word_t'(off)),
                           $sformatf("load f3=%0d at offset %0d", kinds[k], off));
            end
        end
        finish_test("sign and zero extension");
    endtask

    task automatic disabled_paths();
        word_t   addr;
        word_t   got;
        opcode_t others [2] = '{OPC_LOAD, 7'b0110011};
        start_test();
        addr      = $urandom;
        addr[1:0] = 2'b00;
        store_op(F3_W, addr, $urandom | 32'h1);
        foreach (others[k]) begin
            @(negedge clk);
            inst  = make_inst(others[k], F3_W);
            waddr = addr;
            wdata = ~model_word(addr);
            wen   = 1'b1;
            req   = 1'b0;
        end
        load_op(F3_W, addr, got);
        check_mask_effect(addr, got);
        @(negedge clk);
        inst  = make_inst(OPC_LOAD, F3_W);
        raddr = addr;
        wen   = 1'b0;
        req   = 1'b0;
        @(negedge clk);
        check_word(rdata, '0, "load with req low");
        finish_test("write and read gating");
    endtask

    task automatic random_traffic();
        word_t   addr;
        word_t   got;
        funct3_t funct3;
        funct3_t store_kinds [3] = '{F3_B, F3_H, F3_W};
        funct3_t load_kinds [5]  = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
        start_test();
        // the window straddles the top of the RAM, so indices wrap.
        for (int w = 0; w < N_WINDOW; w++) begin
            store_op(F3_W, window_addr(w, 0), $urandom);
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            addr = window_addr(int'($urandom_range(N_WINDOW - 1)), int'($urandom_range(3)));
            if ($urandom_range(1) == 0) begin
                funct3 = store_kinds[$urandom_range(2)];
                store_op(funct3, addr, $urandom);
            end else begin
                funct3 = load_kinds[$urandom_range(4)];
                load_op(funct3, addr, got);
                check_word(got, model_load(funct3, addr),
                           $sformatf("random load f3=%0d at %h", funct3, addr));
            end
        end
        finish_test("random traffic");
    endtask

    initial begin
        void'($urandom(SEED));
        drive_idle();
        reset_then_word();
        masked_stores();
        signed_loads();
        disabled_paths();
        random_traffic();
        @(negedge clk);
        drive_idle();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: test/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset drops on a falling edge, half a cycle away from the write edge.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule
